// File: logic/ctrl_pkg.sv
package ctrl_pkg;

    // core sizes
    localparam int XLEN           = 32;
    localparam int ARCH_REG_NUM   = 32;
    localparam int PHYS_REG_NUM   = 64;
    localparam int ROB_SIZE       = 16;
    localparam int INST_BUF_DEPTH = 8;

    typedef logic [6:0] opcode_t;

    // rv32i major opcodes handled by decode
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    typedef logic [31:0]                       inst_t;
    typedef logic [XLEN-1:0]                   addr_t;
    typedef logic [$clog2(ARCH_REG_NUM)-1:0]   areg_t;
    typedef logic [$clog2(PHYS_REG_NUM)-1:0]   preg_t;
    typedef logic [$clog2(ROB_SIZE)-1:0]       rob_idx_t;

    // fetch -> instruction buffer
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_entry_t;

    // decode -> rename
    typedef struct packed {
        addr_t pc;
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
        logic  has_rd;
        logic  use_rs1;
        logic  use_rs2;
    } dec_info_t;

    // rename -> rob, also the dispatch view
    typedef struct packed {
        addr_t pc;
        areg_t rd;
        logic  has_rd;
        preg_t prd;
        preg_t prs1;
        preg_t prs2;
        preg_t old_prd;
    } rename_info_t;

    // rob -> rename on retirement
    typedef struct packed {
        rob_idx_t rob_idx;
        areg_t    rd;
        logic     has_rd;
        preg_t    prd;
        preg_t    old_prd;
    } commit_info_t;

endpackage

// File: logic/inst_buffer.sv
module inst_buffer #(
    parameter int DEPTH = ctrl_pkg::INST_BUF_DEPTH
) (
    input  wire                    clk,
    input  wire                    i_rst_n,

    // from fetch
    input  wire                    i_inst_vld,
    input  ctrl_pkg::fetch_entry_t i_inst,
    output logic                   o_stall,

    // to decode
    output logic                   o_vld,
    output ctrl_pkg::fetch_entry_t o_entry,
    input  wire                    i_take
);
    import ctrl_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_entry_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             enq;
    logic             deq;

    // wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_stall = (count == CNT_W'(DEPTH));
    assign o_vld   = (count != '0);
    assign o_entry = mem[rd_ptr];

    // offers while full are dropped, fetch holds them
    assign enq = i_inst_vld && !o_stall;
    assign deq = i_take && o_vld;

    always_ff @(posedge clk) begin
        if (enq) begin
            mem[wr_ptr] <= i_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (deq) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/decode.sv
module decode (
    input  wire                    clk,
    input  wire                    i_rst_n,

    // from instruction buffer
    input  wire                    i_vld,
    input  ctrl_pkg::fetch_entry_t i_entry,
    output logic                   o_take,

    // to rename
    input  wire                    i_stall,
    output logic                   o_vld,
    output ctrl_pkg::dec_info_t    o_info
);
    import ctrl_pkg::*;

    opcode_t   opcode;
    areg_t     rd_field;
    areg_t     rs1_field;
    areg_t     rs2_field;
    logic      writes_rd;
    logic      reads_rs1;
    logic      reads_rs2;
    dec_info_t dec_next;

    // standard rv32 field positions
    assign opcode    = i_entry.inst[6:0];
    assign rd_field  = i_entry.inst[11:7];
    assign rs1_field = i_entry.inst[19:15];
    assign rs2_field = i_entry.inst[24:20];

    // register usage per opcode class
    always_comb begin
        writes_rd = 1'b0;
        reads_rs1 = 1'b0;
        reads_rs2 = 1'b0;
        case (opcode)
            OPC_OP: begin
                writes_rd = 1'b1;
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
            end
            OPC_OP_IMM: begin
                writes_rd = 1'b1;
                reads_rs1 = 1'b1;
            end
            OPC_LUI: begin
                writes_rd = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

    // x0 as a destination is not renamed
    always_comb begin
        dec_next.pc      = i_entry.pc;
        dec_next.rd      = writes_rd ? rd_field : '0;
        dec_next.has_rd  = writes_rd && (rd_field != '0);
        dec_next.rs1     = reads_rs1 ? rs1_field : '0;
        dec_next.rs2     = reads_rs2 ? rs2_field : '0;
        dec_next.use_rs1 = reads_rs1;
        dec_next.use_rs2 = reads_rs2;
    end

    assign o_take = i_vld && !i_stall;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_vld <= 1'b0;
        end else if (!i_stall) begin
            o_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (o_take) begin
            o_info <= dec_next;
        end
    end

endmodule

// File: logic/rename.sv
module rename (
    input  wire                      clk,
    input  wire                      i_rst_n,

    // from decode
    input  wire                      i_vld,
    input  ctrl_pkg::dec_info_t      i_info,
    output logic                     o_stall,

    // to rob
    input  wire                      i_rob_full,
    output logic                     o_vld,
    output ctrl_pkg::rename_info_t   o_info,

    // retirement frees the previous mapping
    input  wire                      i_commit_vld,
    input  ctrl_pkg::commit_info_t   i_commit_info
);
    import ctrl_pkg::*;

    localparam int FL_SIZE  = PHYS_REG_NUM - ARCH_REG_NUM;
    localparam int FL_PTR_W = $clog2(FL_SIZE);
    localparam int FL_CNT_W = $clog2(FL_SIZE + 1);

    preg_t               map_table [ARCH_REG_NUM];
    preg_t               free_list [FL_SIZE];
    logic [FL_PTR_W-1:0] fl_head;
    logic [FL_PTR_W-1:0] fl_tail;
    logic [FL_CNT_W-1:0] fl_count;
    logic                fl_empty;
    logic                fl_pop;
    logic                fl_push;
    logic                hold;
    logic                accept;
    rename_info_t        ren_next;

    assign fl_empty = (fl_count == '0);

    // output stuck in front of a full rob
    assign hold    = o_vld && i_rob_full;
    assign o_stall = hold || (i_vld && i_info.has_rd && fl_empty);
    assign accept  = i_vld && !o_stall;

    assign fl_pop  = accept && i_info.has_rd;
    assign fl_push = i_commit_vld && i_commit_info.has_rd;

    // map lookup, x0 and unused sources read physical 0
    always_comb begin
        ren_next.pc      = i_info.pc;
        ren_next.rd      = i_info.rd;
        ren_next.has_rd  = i_info.has_rd;
        ren_next.prs1    = (i_info.use_rs1 && (i_info.rs1 != '0)) ?
                           map_table[i_info.rs1] : '0;
        ren_next.prs2    = (i_info.use_rs2 && (i_info.rs2 != '0)) ?
                           map_table[i_info.rs2] : '0;
        ren_next.prd     = i_info.has_rd ? free_list[fl_head] : '0;
        ren_next.old_prd = i_info.has_rd ? map_table[i_info.rd] : '0;
    end

    // speculative map, identity out of reset
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < ARCH_REG_NUM; i++) begin
                map_table[i] <= preg_t'(i);
            end
        end else if (fl_pop) begin
            map_table[i_info.rd] <= free_list[fl_head];
        end
    end

    // free list fifo, starts full with the upper physical registers
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < FL_SIZE; i++) begin
                free_list[i] <= preg_t'(ARCH_REG_NUM + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= FL_CNT_W'(FL_SIZE);
        end else begin
            if (fl_push) begin
                free_list[fl_tail] <= i_commit_info.old_prd;
                fl_tail            <= fl_tail + 1'b1;
            end
            if (fl_pop) begin
                fl_head <= fl_head + 1'b1;
            end
            case ({fl_push, fl_pop})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_vld <= 1'b0;
        end else if (!hold) begin
            o_vld <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_info <= ren_next;
        end
    end

endmodule

// File: logic/rob.sv
module rob (
    input  wire                    clk,
    input  wire                    i_rst_n,

    // allocation from rename
    input  wire                    i_vld,
    input  ctrl_pkg::rename_info_t i_info,
    output logic                   o_full,
    output ctrl_pkg::rob_idx_t     o_alloc_idx,

    // writeback from execution units
    input  wire                    i_wb_vld,
    input  ctrl_pkg::rob_idx_t     i_wb_rob_idx,

    // in-order retirement
    output logic                   o_commit_vld,
    output ctrl_pkg::commit_info_t o_commit_info
);
    import ctrl_pkg::*;

    localparam int CNT_W = $clog2(ROB_SIZE + 1);

    // what retirement needs to know about an entry
    typedef struct packed {
        areg_t rd;
        logic  has_rd;
        preg_t prd;
        preg_t old_prd;
    } rob_entry_t;

    rob_entry_t          entries [ROB_SIZE];
    logic [ROB_SIZE-1:0] done;
    rob_idx_t            head;
    rob_idx_t            tail;
    logic [CNT_W-1:0]    count;
    logic                alloc;
    logic                retire;
    rob_entry_t          head_entry;

    assign o_full      = (count == CNT_W'(ROB_SIZE));
    assign o_alloc_idx = tail;
    assign alloc       = i_vld && !o_full;

    assign head_entry = entries[head];
    assign retire     = (count != '0) && done[head];

    always_ff @(posedge clk) begin
        if (alloc) begin
            entries[tail] <= '{
                rd:      i_info.rd,
                has_rd:  i_info.has_rd,
                prd:     i_info.prd,
                old_prd: i_info.old_prd
            };
        end
    end

    // completion flags, cleared as the slot is reused
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            done <= '0;
        end else begin
            if (alloc) begin
                done[tail] <= 1'b0;
            end
            if (i_wb_vld) begin
                done[i_wb_rob_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one pulse per retired entry
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_commit_vld <= 1'b0;
        end else begin
            o_commit_vld <= retire;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            o_commit_info.rob_idx <= head;
            o_commit_info.rd      <= head_entry.rd;
            o_commit_info.has_rd  <= head_entry.has_rd;
            o_commit_info.prd     <= head_entry.prd;
            o_commit_info.old_prd <= head_entry.old_prd;
        end
    end

endmodule

// File: logic/ctrl_block.sv
module ctrl_block (
    input  wire                    clk,
    input  wire                    i_rst_n,

    // fetch
    input  wire                    i_inst_vld,
    input  ctrl_pkg::fetch_entry_t i_inst,
    output logic                   o_stall,

    // writeback
    input  wire                    i_wb_vld,
    input  ctrl_pkg::rob_idx_t     i_wb_rob_idx,

    // dispatch
    output logic                   o_disp_vld,
    output ctrl_pkg::rename_info_t o_disp_info,
    output ctrl_pkg::rob_idx_t     o_disp_rob_idx,

    // commit
    output logic                   o_commit_vld,
    output ctrl_pkg::commit_info_t o_commit_info
);
    import ctrl_pkg::*;

    logic         buf_vld;
    fetch_entry_t buf_entry;
    logic         dec_take;
    logic         dec_vld;
    dec_info_t    dec_info;
    logic         dec_stall;
    logic         ren_vld;
    rename_info_t ren_info;
    logic         rob_full;
    logic         commit_vld;
    commit_info_t commit_info;

    inst_buffer u_inst_buffer (
        .clk        ( clk        ),
        .i_rst_n    ( i_rst_n    ),
        .i_inst_vld ( i_inst_vld ),
        .i_inst     ( i_inst     ),
        .o_stall    ( o_stall    ),
        .o_vld      ( buf_vld    ),
        .o_entry    ( buf_entry  ),
        .i_take     ( dec_take   )
    );

    decode u_decode (
        .clk     ( clk       ),
        .i_rst_n ( i_rst_n   ),
        .i_vld   ( buf_vld   ),
        .i_entry ( buf_entry ),
        .o_take  ( dec_take  ),
        .i_stall ( dec_stall ),
        .o_vld   ( dec_vld   ),
        .o_info  ( dec_info  )
    );

    rename u_rename (
        .clk           ( clk         ),
        .i_rst_n       ( i_rst_n     ),
        .i_vld         ( dec_vld     ),
        .i_info        ( dec_info    ),
        .o_stall       ( dec_stall   ),
        .i_rob_full    ( rob_full    ),
        .o_vld         ( ren_vld     ),
        .o_info        ( ren_info    ),
        .i_commit_vld  ( commit_vld  ),
        .i_commit_info ( commit_info )
    );

    rob u_rob (
        .clk           ( clk            ),
        .i_rst_n       ( i_rst_n        ),
        .i_vld         ( ren_vld        ),
        .i_info        ( ren_info       ),
        .o_full        ( rob_full       ),
        .o_alloc_idx   ( o_disp_rob_idx ),
        .i_wb_vld      ( i_wb_vld       ),
        .i_wb_rob_idx  ( i_wb_rob_idx   ),
        .o_commit_vld  ( commit_vld     ),
        .o_commit_info ( commit_info    )
    );

    // dispatch is the rob allocation itself
    assign o_disp_vld    = ren_vld && !rob_full;
    assign o_disp_info   = ren_info;
    assign o_commit_vld  = commit_vld;
    assign o_commit_info = commit_info;

endmodule

// File: verification/tb_ctrl_block.sv
module tb_ctrl_block;
    import ctrl_pkg::*;

    localparam int NUM_INST = 200;
    // rob entries plus decode, rename and buffer slots ahead of a full rob
    localparam int FILL_DEPTH = ROB_SIZE + 2 + INST_BUF_DEPTH;

    logic         clk;
    logic         i_rst_n;
    logic         i_inst_vld;
    fetch_entry_t i_inst;
    logic         o_stall;
    logic         i_wb_vld;
    rob_idx_t     i_wb_rob_idx;
    logic         o_disp_vld;
    rename_info_t o_disp_info;
    rob_idx_t     o_disp_rob_idx;
    logic         o_commit_vld;
    commit_info_t o_commit_info;

    // stimulus side
    logic [15:0]  lfsr_state;
    fetch_entry_t stim [NUM_INST];
    int           sent_cnt;
    logic         offer_pending;
    rob_idx_t     outstanding [$];
    logic         wb_issued [ROB_SIZE];
    logic         nxt_wb_vld;
    rob_idx_t     nxt_wb_idx;

    // reference model
    preg_t        model_map [ARCH_REG_NUM];
    preg_t        model_fl [$];
    commit_info_t disp_q [$];
    rob_idx_t     exp_rob_idx;
    int           disp_cnt;
    int           commit_cnt;

    ctrl_block i_ctrl_block (
        .clk            ( clk            ),
        .i_rst_n        ( i_rst_n        ),
        .i_inst_vld     ( i_inst_vld     ),
        .i_inst         ( i_inst         ),
        .o_stall        ( o_stall        ),
        .i_wb_vld       ( i_wb_vld       ),
        .i_wb_rob_idx   ( i_wb_rob_idx   ),
        .o_disp_vld     ( o_disp_vld     ),
        .o_disp_info    ( o_disp_info    ),
        .o_disp_rob_idx ( o_disp_rob_idx ),
        .o_commit_vld   ( o_commit_vld   ),
        .o_commit_info  ( o_commit_info  )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic fetch_entry_t make_entry(input int n);
        fetch_entry_t e;
        opcode_t      opc;
        areg_t        rd;
        areg_t        rs1;
        areg_t        rs2;
        logic [6:0]   funct7;
        logic [2:0]   funct3;
        case (int'(take_bits(3)) % 6)
            0:       opc = OPC_OP;
            1:       opc = OPC_OP_IMM;
            2:       opc = OPC_LUI;
            3:       opc = OPC_STORE;
            4:       opc = OPC_BRANCH;
            default: opc = 7'b1110011;
        endcase
        // narrow rd range so x0 and register reuse show up often
        rd     = areg_t'(take_bits(3));
        rs1    = areg_t'(take_bits(5));
        rs2    = areg_t'(take_bits(5));
        funct7 = 7'(take_bits(7));
        funct3 = 3'(take_bits(3));
        e.pc   = addr_t'(32'h1000 + 4 * n);
        e.inst = {funct7, rs2, rs1, funct3, rd, opc};
        return e;
    endfunction

    function automatic dec_info_t decode_ref(input fetch_entry_t e);
        dec_info_t d;
        opcode_t   opc;
        logic      wr;
        logic      r1;
        logic      r2;
        opc = e.inst[6:0];
        wr  = (opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_LUI);
        r2  = (opc == OPC_OP) || (opc == OPC_STORE) || (opc == OPC_BRANCH);
        r1  = r2 || (opc == OPC_OP_IMM);
        d.pc      = e.pc;
        d.rd      = wr ? e.inst[11:7] : '0;
        d.has_rd  = wr && (e.inst[11:7] != 5'd0);
        d.rs1     = r1 ? e.inst[19:15] : '0;
        d.rs2     = r2 ? e.inst[24:20] : '0;
        d.use_rs1 = r1;
        d.use_rs2 = r2;
        return d;
    endfunction

    // expected rename result that also advances the model map and free list
    function automatic rename_info_t rename_ref(input dec_info_t d);
        rename_info_t r;
        r.pc      = d.pc;
        r.rd      = d.rd;
        r.has_rd  = d.has_rd;
        r.prs1    = (d.use_rs1 && (d.rs1 != '0)) ? model_map[d.rs1] : '0;
        r.prs2    = (d.use_rs2 && (d.rs2 != '0)) ? model_map[d.rs2] : '0;
        r.prd     = '0;
        r.old_prd = '0;
        if (d.has_rd) begin
            r.old_prd       = model_map[d.rd];
            r.prd           = model_fl.pop_front();
            model_map[d.rd] = r.prd;
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        if (why.len() > 0) begin
            $display("%s", why);
        end
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
            abort_run("");
        end
    endtask

    task automatic check_dispatch();
        dec_info_t    dec;
        rename_info_t exp;
        commit_info_t rec;
        assert (disp_cnt < sent_cnt)
            else abort_run("an instruction was dispatched that fetch never delivered");
        dec = decode_ref(stim[disp_cnt]);
        assert (!dec.has_rd || model_fl.size() > 0)
            else abort_run("the reference free list ran empty");
        exp = rename_ref(dec);
        check_value("o_disp_info.pc", exp.pc, o_disp_info.pc);
        check_value("o_disp_info.rd", 32'(exp.rd), 32'(o_disp_info.rd));
        check_value("o_disp_info.has_rd", 32'(exp.has_rd), 32'(o_disp_info.has_rd));
        check_value("o_disp_info.prd", 32'(exp.prd), 32'(o_disp_info.prd));
        check_value("o_disp_info.prs1", 32'(exp.prs1), 32'(o_disp_info.prs1));
        check_value("o_disp_info.prs2", 32'(exp.prs2), 32'(o_disp_info.prs2));
        check_value("o_disp_info.old_prd", 32'(exp.old_prd), 32'(o_disp_info.old_prd));
        check_value("o_disp_rob_idx", 32'(exp_rob_idx), 32'(o_disp_rob_idx));
        rec.rob_idx = exp_rob_idx;
        rec.rd      = exp.rd;
        rec.has_rd  = exp.has_rd;
        rec.prd     = exp.prd;
        rec.old_prd = exp.old_prd;
        disp_q.push_back(rec);
        exp_rob_idx = rob_idx_t'(exp_rob_idx + 1);
        disp_cnt++;
    endtask

    task automatic check_commit();
        commit_info_t exp;
        assert (disp_q.size() > 0)
            else abort_run("a commit arrived with no dispatched instruction in flight");
        exp = disp_q.pop_front();
        check_value("o_commit_info.rob_idx", 32'(exp.rob_idx), 32'(o_commit_info.rob_idx));
        check_value("o_commit_info.rd", 32'(exp.rd), 32'(o_commit_info.rd));
        check_value("o_commit_info.has_rd", 32'(exp.has_rd), 32'(o_commit_info.has_rd));
        check_value("o_commit_info.prd", 32'(exp.prd), 32'(o_commit_info.prd));
        check_value("o_commit_info.old_prd", 32'(exp.old_prd), 32'(o_commit_info.old_prd));
        assert (wb_issued[exp.rob_idx]) else begin
            abort_run($sformatf("rob index %0d committed before its writeback", exp.rob_idx));
        end
        if (exp.has_rd) begin
            model_fl.push_back(exp.old_prd);
        end
        commit_cnt++;
    endtask

    // next fetch offer and writeback from the values seen at this edge
    task automatic plan_cycle(input logic fill);
        int sel;
        if (i_inst_vld && !o_stall) begin
            sent_cnt++;
            offer_pending = 1'b0;
        end
        if (!offer_pending && sent_cnt < NUM_INST) begin
            offer_pending = fill || next_bit();
        end
        if (o_disp_vld) begin
            outstanding.push_back(o_disp_rob_idx);
            wb_issued[o_disp_rob_idx] = 1'b0;
        end
        nxt_wb_vld = 1'b0;
        if (!fill && outstanding.size() > 0 && next_bit()) begin
            sel        = int'(take_bits(4)) % outstanding.size();
            nxt_wb_idx = outstanding[sel];
            outstanding.delete(sel);
            wb_issued[nxt_wb_idx] = 1'b1;
            nxt_wb_vld = 1'b1;
        end
    endtask

    initial begin : stimulus
        logic fill;
        int   stall_cycles;
        i_rst_n      <= 1'b0;
        i_inst_vld   <= 1'b0;
        i_inst       <= '0;
        i_wb_vld     <= 1'b0;
        i_wb_rob_idx <= '0;
        lfsr_state    = 16'd7;
        sent_cnt      = 0;
        offer_pending = 1'b0;
        nxt_wb_vld    = 1'b0;
        nxt_wb_idx    = '0;
        fill          = 1'b1;
        stall_cycles  = 0;
        for (int i = 0; i < ROB_SIZE; i++) begin
            wb_issued[i] = 1'b0;
        end
        for (int n = 0; n < NUM_INST; n++) begin
            stim[n] = make_entry(n);
        end
        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        check_value("o_stall", 32'd0, 32'(o_stall));
        check_value("o_disp_vld", 32'd0, 32'(o_disp_vld));
        check_value("o_commit_vld", 32'd0, 32'(o_commit_vld));
        while (commit_cnt < NUM_INST) begin
            @(posedge clk);
            plan_cycle(fill);
            i_inst_vld   <= offer_pending;
            i_inst       <= stim[sent_cnt % NUM_INST];
            i_wb_vld     <= nxt_wb_vld;
            i_wb_rob_idx <= nxt_wb_idx;
            // writeback withheld until the whole front end has backed up
            if (fill && o_stall) begin
                stall_cycles++;
                if (stall_cycles == 1 || stall_cycles == 5) begin
                    check_value("dispatches without writeback", 32'(ROB_SIZE), 32'(disp_cnt));
                    check_value("fetch accepts before o_stall", 32'(FILL_DEPTH), 32'(sent_cnt));
                    check_value("o_disp_vld", 32'd0, 32'(o_disp_vld));
                end
                if (stall_cycles == 5) begin
                    fill = 1'b0;
                end
            end
        end
        $display("All checks passed");
        $finish;
    end

    initial begin : compare
        disp_cnt    = 0;
        commit_cnt  = 0;
        exp_rob_idx = '0;
        for (int i = 0; i < ARCH_REG_NUM; i++) begin
            model_map[i] = preg_t'(i);
        end
        for (int i = 0; i < PHYS_REG_NUM - ARCH_REG_NUM; i++) begin
            model_fl.push_back(preg_t'(ARCH_REG_NUM + i));
        end
        forever begin
            @(negedge clk);
            // commit before dispatch since a freed rob slot can refill in the same cycle
            if (i_rst_n) begin
                if (o_commit_vld) begin
                    check_commit();
                end
                if (o_disp_vld) begin
                    check_dispatch();
                end
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_INST * 40) @(posedge clk);
        abort_run($sformatf("timeout, the pipeline stopped making progress (%0d of %0d committed)",
                            commit_cnt, NUM_INST));
    end

endmodule

// File: sources.f
logic/ctrl_pkg.sv
logic/inst_buffer.sv
logic/decode.sv
logic/rename.sv
logic/rob.sv
logic/ctrl_block.sv
verification/tb_ctrl_block.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" && rm -f sim.log &&
verilator --binary --timing --assert -j 0 --top-module tb_ctrl_block -f sources.f &&
{ ./obj_dir/Vtb_ctrl_block 2>&1 | tee sim.log; } &&
! grep -q "Checks failed" sim.log &&
echo "simulation run clean" ||
{ echo "simulation run failed"; exit 1; }
